//--- hw/cpu_pkg.sv
package cpu_pkg;

    ////////////////////////////////////////
    // widths and reset values
    ////////////////////////////////////////

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;
    localparam logic [ADDR_W-1:0] RESET_PC = 16'hC000;
    localparam int STEP_W = 2;
    localparam int MAX_STEPS = 4;
    localparam int UIDX_W = 4;

    // micro-program entry points
    localparam logic [UIDX_W-1:0] UIDX_DONE = 4'd0;
    localparam logic [UIDX_W-1:0] UIDX_LDA = 4'd1;
    localparam logic [UIDX_W-1:0] UIDX_LDX = 4'd2;
    localparam logic [UIDX_W-1:0] UIDX_ADC = 4'd3;
    localparam logic [UIDX_W-1:0] UIDX_SBC = 4'd4;
    localparam logic [UIDX_W-1:0] UIDX_AND = 4'd5;
    localparam logic [UIDX_W-1:0] UIDX_EOR = 4'd6;
    localparam logic [UIDX_W-1:0] UIDX_STA = 4'd7;
    localparam logic [UIDX_W-1:0] UIDX_STX = 4'd8;
    localparam logic [UIDX_W-1:0] UIDX_INX = 4'd9;
    localparam logic [UIDX_W-1:0] UIDX_TAX = 4'd10;
    localparam logic [UIDX_W-1:0] UIDX_BR = 4'd11;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        STATE_FETCH = 2'd0,
        STATE_DECODE = 2'd1,
        STATE_EXEC = 2'd2
    } cpu_state_e;

    // 6502 encodings, immediate / zero page forms only
    typedef enum logic [7:0] {
        OP_LDA = 8'hA9,
        OP_LDX = 8'hA2,
        OP_ADC = 8'h69,
        OP_SBC = 8'hE9,
        OP_AND = 8'h29,
        OP_EOR = 8'h49,
        OP_STA = 8'h85,
        OP_STX = 8'h86,
        OP_INX = 8'hE8,
        OP_TAX = 8'hAA,
        OP_CLC = 8'h18,
        OP_SEC = 8'h38,
        OP_NOP = 8'hEA,
        OP_BEQ = 8'hF0,
        OP_BNE = 8'hD0,
        OP_BCC = 8'h90,
        OP_BCS = 8'hB0
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_HOLD, ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_EOR, ALU_INC
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A, SRC_X, SRC_RBUF} alu_src_e;
    typedef enum logic [1:0] {DST_NONE, DST_A, DST_X, DST_MEM} alu_dst_e;
    typedef enum logic {ADDR_PC, ADDR_ZP} addr_src_e;
    typedef enum logic {BR_Z, BR_C} branch_cond_e;

    typedef struct packed {
        alu_op_e alu_op;
        alu_src_e alu_src;
        alu_dst_e alu_dst;
        addr_src_e addr_src;
        logic read;
        logic write;
        logic inc_pc;
        logic update_nz;
        logic update_c;
        logic last;
    } uop_t;

    typedef struct packed {
        logic [STEP_W-1:0] steps;
        logic branch;
        branch_cond_e branch_cond;
        logic branch_inv;
        logic flag_val;
        logic flag_set;
        logic [UIDX_W-1:0] uop_idx;
    } decode_t;

    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] x;
        logic [ADDR_W-1:0] pc;
        logic n;
        logic z;
        logic c;
    } reg_state_t;

    typedef struct packed {
        logic [DATA_W-1:0] value;
        logic n;
        logic z;
        logic c;
    } alu_result_t;

    localparam uop_t UOP_NONE = '{alu_op: ALU_HOLD, alu_src: SRC_A, alu_dst: DST_NONE,
                                  addr_src: ADDR_PC, default: 1'b0};
    localparam uop_t UOP_READ = '{alu_op: ALU_HOLD, alu_src: SRC_A, alu_dst: DST_NONE,
                                  addr_src: ADDR_PC, read: 1'b1, inc_pc: 1'b1,
                                  default: 1'b0};
    localparam uop_t UOP_DONE = '{alu_op: ALU_HOLD, alu_src: SRC_A, alu_dst: DST_NONE,
                                  addr_src: ADDR_PC, last: 1'b1, default: 1'b0};

    localparam decode_t DECODE_NOP = '{steps: '0, branch: 1'b0, branch_cond: BR_Z,
                                       branch_inv: 1'b0, flag_val: 1'b0, flag_set: 1'b0,
                                       uop_idx: UIDX_DONE};

    ////////////////////////////////////////
    // microcode and decode tables
    ////////////////////////////////////////

    function automatic uop_t alu_uop(alu_op_e op, alu_src_e src);
        uop_t u;
        u = UOP_NONE;
        u.alu_op = op;
        u.alu_src = src;
        return u;
    endfunction

    // write-back of the ALU register, always sets N and Z
    function automatic uop_t wb_uop(alu_dst_e dst, logic upd_c);
        uop_t u;
        u = UOP_DONE;
        u.alu_dst = dst;
        u.update_nz = 1'b1;
        u.update_c = upd_c;
        return u;
    endfunction

    function automatic uop_t store_uop(alu_src_e src);
        uop_t u;
        u = UOP_DONE;
        u.alu_src = src;
        u.alu_dst = DST_MEM;
        u.addr_src = ADDR_ZP;
        u.write = 1'b1;
        return u;
    endfunction

    // operand read, ALU step, write-back
    function automatic uop_t imm_uop(logic [STEP_W-1:0] step, alu_op_e op, alu_src_e src,
                                     alu_dst_e dst, logic upd_c);
        case (step)
            2'd0: return UOP_READ;
            2'd1: return alu_uop(op, src);
            default: return wb_uop(dst, upd_c);
        endcase
    endfunction

    function automatic uop_t uop_lookup(logic [UIDX_W-1:0] idx, logic [STEP_W-1:0] step);
        case (idx)
            UIDX_LDA: return imm_uop(step, ALU_PASS, SRC_RBUF, DST_A, 1'b0);
            UIDX_LDX: return imm_uop(step, ALU_PASS, SRC_RBUF, DST_X, 1'b0);
            UIDX_ADC: return imm_uop(step, ALU_ADD, SRC_A, DST_A, 1'b1);
            UIDX_SBC: return imm_uop(step, ALU_SUB, SRC_A, DST_A, 1'b1);
            UIDX_AND: return imm_uop(step, ALU_AND, SRC_A, DST_A, 1'b0);
            UIDX_EOR: return imm_uop(step, ALU_EOR, SRC_A, DST_A, 1'b0);
            UIDX_STA: return (step == '0) ? UOP_READ : store_uop(SRC_A);
            UIDX_STX: return (step == '0) ? UOP_READ : store_uop(SRC_X);
            UIDX_INX: return (step == '0) ? alu_uop(ALU_INC, SRC_X) : wb_uop(DST_X, 1'b0);
            UIDX_TAX: return (step == '0) ? alu_uop(ALU_PASS, SRC_A) : wb_uop(DST_X, 1'b0);
            // offset read, then the taken step
            UIDX_BR: return (step == '0) ? UOP_READ : UOP_DONE;
            default: return UOP_DONE;
        endcase
    endfunction

    function automatic decode_t dec_entry(logic [STEP_W-1:0] steps, logic [UIDX_W-1:0] idx);
        decode_t d;
        d = DECODE_NOP;
        d.steps = steps;
        d.uop_idx = idx;
        return d;
    endfunction

    function automatic decode_t br_entry(branch_cond_e cond, logic inv);
        decode_t d;
        d = dec_entry(2'd2, UIDX_BR);
        d.branch = 1'b1;
        d.branch_cond = cond;
        d.branch_inv = inv;
        return d;
    endfunction

    function automatic decode_t flag_entry(logic val);
        decode_t d;
        d = dec_entry(2'd1, UIDX_DONE);
        d.flag_set = 1'b1;
        d.flag_val = val;
        return d;
    endfunction

    function automatic decode_t decode_opcode(logic [DATA_W-1:0] op);
        case (op)
            OP_LDA: return dec_entry(2'd3, UIDX_LDA);
            OP_LDX: return dec_entry(2'd3, UIDX_LDX);
            OP_ADC: return dec_entry(2'd3, UIDX_ADC);
            OP_SBC: return dec_entry(2'd3, UIDX_SBC);
            OP_AND: return dec_entry(2'd3, UIDX_AND);
            OP_EOR: return dec_entry(2'd3, UIDX_EOR);
            OP_STA: return dec_entry(2'd2, UIDX_STA);
            OP_STX: return dec_entry(2'd2, UIDX_STX);
            OP_INX: return dec_entry(2'd2, UIDX_INX);
            OP_TAX: return dec_entry(2'd2, UIDX_TAX);
            OP_CLC: return flag_entry(1'b0);
            OP_SEC: return flag_entry(1'b1);
            OP_BEQ: return br_entry(BR_Z, 1'b0);
            OP_BNE: return br_entry(BR_Z, 1'b1);
            OP_BCC: return br_entry(BR_C, 1'b1);
            OP_BCS: return br_entry(BR_C, 1'b0);
            OP_NOP: return DECODE_NOP;
            // anything else runs as NOP
            default: return DECODE_NOP;
        endcase
    endfunction

endpackage

//--- hw/cpu_alu.sv
`timescale 1ns/1ns

module cpu_alu
    import cpu_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset_n,
    input  logic              i_clock_en,
    input  uop_t              i_uop,
    input  reg_state_t        i_regs,
    input  logic [DATA_W-1:0] i_rbuf_data,
    output alu_result_t       o_alu
);

    logic [DATA_W-1:0] src1;
    logic [DATA_W-1:0] src2;
    logic [DATA_W:0] sum;
    alu_result_t result;
    alu_result_t alu_q;

    always_comb begin
        case (i_uop.alu_src)
            SRC_X: src1 = i_regs.x;
            SRC_RBUF: src1 = i_rbuf_data;
            default: src1 = i_regs.a;
        endcase
    end

    // 6502 subtract, carry in is not-borrow
    assign src2 = (i_uop.alu_op == ALU_SUB) ? ~i_rbuf_data : i_rbuf_data;
    assign sum = {1'b0, src1} + {1'b0, src2} + {{DATA_W{1'b0}}, i_regs.c};

    always_comb begin
        result.value = src1;
        result.c = alu_q.c;
        case (i_uop.alu_op)
            ALU_ADD, ALU_SUB: begin
                result.value = sum[DATA_W-1:0];
                result.c = sum[DATA_W];
            end
            ALU_AND: result.value = src1 & i_rbuf_data;
            ALU_EOR: result.value = src1 ^ i_rbuf_data;
            ALU_INC: result.value = src1 + 1'b1;
            default: result.value = src1;
        endcase
        result.n = result.value[DATA_W-1];
        result.z = (result.value == '0);
    end

    always_ff @(posedge i_clock or negedge i_reset_n) begin
        if (!i_reset_n) begin
            alu_q <= '0;
        end else if (i_clock_en && i_uop.alu_op != ALU_HOLD) begin
            alu_q <= result;
        end
    end

    assign o_alu = alu_q;

endmodule

//--- hw/cpu_mem_if.sv
`timescale 1ns/1ns

module cpu_mem_if
    import cpu_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset_n,
    input  logic              i_clock_en,
    input  cpu_state_e        i_state,
    input  uop_t              i_uop,
    input  reg_state_t        i_regs,
    input  logic [DATA_W-1:0] i_r_data,
    output logic [ADDR_W-1:0] o_addr,
    output logic              o_mem_r_en,
    output logic [DATA_W-1:0] o_w_data,
    output logic [DATA_W-1:0] o_rbuf_data
);

    logic addr_sel;
    logic [ADDR_W-1:0] next_addr;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] rbuf_q;

    assign addr_sel = (i_state == STATE_FETCH) || i_uop.read || i_uop.write;

    // zero page address comes from the buffered operand
    assign next_addr = (i_uop.addr_src == ADDR_ZP) ? {{(ADDR_W-DATA_W){1'b0}}, rbuf_q}
                                                   : i_regs.pc;

    // write-through, a new address shows up in the same cycle
    assign o_addr = addr_sel ? next_addr : addr_q;
    assign o_mem_r_en = !i_uop.write;
    assign o_w_data = (i_uop.alu_dst == DST_MEM && i_uop.alu_src == SRC_X) ? i_regs.x
                                                                            : i_regs.a;

    always_ff @(posedge i_clock or negedge i_reset_n) begin
        if (!i_reset_n) begin
            addr_q <= RESET_PC;
        end else if (i_clock_en && addr_sel) begin
            addr_q <= next_addr;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_clock_en && o_mem_r_en) begin
            rbuf_q <= i_r_data;
        end
    end

    assign o_rbuf_data = rbuf_q;

    a_write_in_exec: assert property (@(posedge i_clock) disable iff (!i_reset_n)
        !o_mem_r_en |-> (i_state == STATE_EXEC));

endmodule

//--- hw/cpu_regs.sv
`timescale 1ns/1ns

module cpu_regs
    import cpu_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset_n,
    input  logic              i_clock_en,
    input  cpu_state_e        i_state,
    input  decode_t           i_decode,
    input  uop_t              i_uop,
    input  alu_result_t       i_alu,
    input  logic [DATA_W-1:0] i_rbuf_data,
    output reg_state_t        o_regs,
    output logic              o_branch_taken
);

    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] x_q;
    logic [ADDR_W-1:0] pc_q;
    logic n_q;
    logic z_q;
    logic c_q;
    logic in_exec;
    logic a_load;
    logic x_load;
    logic c_load;
    logic pc_inc;
    logic pc_branch;
    logic [ADDR_W-1:0] offset;

    assign in_exec = (i_state == STATE_EXEC);

    // uop is idle outside EXEC
    assign a_load = (i_uop.alu_dst == DST_A);
    assign x_load = (i_uop.alu_dst == DST_X);
    assign c_load = i_uop.update_c || (in_exec && i_decode.flag_set);

    assign o_branch_taken = ((i_decode.branch_cond == BR_Z) ? z_q : c_q) ^ i_decode.branch_inv;

    assign pc_inc = (i_state == STATE_FETCH) || i_uop.inc_pc;
    assign pc_branch = in_exec && i_decode.branch && o_branch_taken && i_uop.last;
    assign offset = {{(ADDR_W-DATA_W){i_rbuf_data[DATA_W-1]}}, i_rbuf_data};

    always_ff @(posedge i_clock or negedge i_reset_n) begin
        if (!i_reset_n) begin
            a_q <= '0;
            x_q <= '0;
            pc_q <= RESET_PC;
            n_q <= 1'b0;
            z_q <= 1'b0;
            c_q <= 1'b0;
        end else if (i_clock_en) begin
            if (a_load) begin
                a_q <= i_alu.value;
            end
            if (x_load) begin
                x_q <= i_alu.value;
            end
            if (i_uop.update_nz) begin
                n_q <= i_alu.n;
                z_q <= i_alu.z;
            end
            if (c_load) begin
                c_q <= i_uop.update_c ? i_alu.c : i_decode.flag_val;
            end
            // relative target from the address after the offset byte
            if (pc_branch) begin
                pc_q <= pc_q + offset;
            end else if (pc_inc) begin
                pc_q <= pc_q + ADDR_W'(1);
            end
        end
    end

    assign o_regs = '{a: a_q, x: x_q, pc: pc_q, n: n_q, z: z_q, c: c_q};

    // A and X only load in the closing write-back step
    a_load_at_wb: assert property (@(posedge i_clock) disable iff (!i_reset_n)
        (a_load || x_load) |-> (in_exec && i_uop.last && i_uop.update_nz));

endmodule

//--- hw/cpu_sequencer.sv
`timescale 1ns/1ns

module cpu_sequencer
    import cpu_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset_n,
    input  logic              i_clock_en,
    input  logic [DATA_W-1:0] i_rbuf_data,
    input  logic              i_branch_taken,
    output cpu_state_e        o_state,
    output decode_t           o_decode,
    output uop_t              o_uop
);

    cpu_state_e state;
    cpu_state_e next_state;
    decode_t decode_q;
    decode_t decode_next;
    logic [STEP_W-1:0] step;
    logic [STEP_W-1:0] next_step;
    logic end_instr;

    // opcode sits in the read buffer during DECODE
    assign decode_next = decode_opcode(i_rbuf_data);

    assign o_uop = (state == STATE_EXEC) ? uop_lookup(decode_q.uop_idx, step) : UOP_NONE;

    // failing branch stops after the offset read
    assign end_instr = o_uop.last || (decode_q.branch && !i_branch_taken);

    always_comb begin
        next_state = state;
        next_step = step;
        case (state)
            STATE_FETCH: begin
                next_state = STATE_DECODE;
            end
            STATE_DECODE: begin
                next_step = '0;
                next_state = (decode_next.steps != '0) ? STATE_EXEC : STATE_FETCH;
            end
            STATE_EXEC: begin
                if (end_instr) begin
                    next_state = STATE_FETCH;
                    next_step = '0;
                end else begin
                    next_step = step + 1'b1;
                end
            end
            default: begin
                next_state = STATE_FETCH;
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state <= STATE_FETCH;
            step <= '0;
            decode_q <= DECODE_NOP;
        end else if (i_clock_en) begin
            state <= next_state;
            step <= next_step;
            if (state == STATE_DECODE) begin
                decode_q <= decode_next;
            end
        end
    end

    assign o_state = state;
    assign o_decode = decode_q;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_state_legal: assert property (@(posedge i_clock) disable iff (!i_reset_n)
        state inside {STATE_FETCH, STATE_DECODE, STATE_EXEC});

    // every micro-program ends before the step index runs out
    a_step_bound: assert property (@(posedge i_clock) disable iff (!i_reset_n)
        (state == STATE_EXEC && !end_instr) |-> (int'(step) + 1 < MAX_STEPS));

endmodule

//--- hw/cpu_core.sv
`timescale 1ns/1ns

module cpu_core
    import cpu_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset_n,
    input  logic              i_clock_en,
    input  logic [DATA_W-1:0] i_r_data,
    output logic [ADDR_W-1:0] o_addr,
    output logic              o_mem_r_en,
    output logic [DATA_W-1:0] o_w_data
);

    cpu_state_e state;
    decode_t decode;
    uop_t uop;
    reg_state_t regs;
    alu_result_t alu;
    logic branch_taken;
    logic [DATA_W-1:0] rbuf_data;

    cpu_sequencer sequencer_inst (
        .i_clock        (i_clock),
        .i_reset_n      (i_reset_n),
        .i_clock_en     (i_clock_en),
        .i_rbuf_data    (rbuf_data),
        .i_branch_taken (branch_taken),
        .o_state        (state),
        .o_decode       (decode),
        .o_uop          (uop)
    );

    cpu_regs regs_inst (
        .i_clock        (i_clock),
        .i_reset_n      (i_reset_n),
        .i_clock_en     (i_clock_en),
        .i_state        (state),
        .i_decode       (decode),
        .i_uop          (uop),
        .i_alu          (alu),
        .i_rbuf_data    (rbuf_data),
        .o_regs         (regs),
        .o_branch_taken (branch_taken)
    );

    cpu_alu alu_inst (
        .i_clock     (i_clock),
        .i_reset_n   (i_reset_n),
        .i_clock_en  (i_clock_en),
        .i_uop       (uop),
        .i_regs      (regs),
        .i_rbuf_data (rbuf_data),
        .o_alu       (alu)
    );

    cpu_mem_if mem_if_inst (
        .i_clock     (i_clock),
        .i_reset_n   (i_reset_n),
        .i_clock_en  (i_clock_en),
        .i_state     (state),
        .i_uop       (uop),
        .i_regs      (regs),
        .i_r_data    (i_r_data),
        .o_addr      (o_addr),
        .o_mem_r_en  (o_mem_r_en),
        .o_w_data    (o_w_data),
        .o_rbuf_data (rbuf_data)
    );

endmodule

//--- testbench/tb_cpu_model.svh
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

////////////////////////////////////////
// instruction level reference model
////////////////////////////////////////

typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
} mem_write_t;

// stores in program order
mem_write_t expected_q[$];

task automatic run_model();
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] op;
    logic [DATA_W-1:0] arg;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] res;
    int wide;
    logic z;
    logic c;
    logic upd_nz;
    logic take;
    mem_write_t wr;
    pc = RESET_PC;
    a = '0;
    x = '0;
    z = 1'b0;
    c = 1'b0;
    // with forward branches only the pc leaves the program for good
    while (pc < prog_end) begin
        op = mem[pc];
        arg = mem[pc + 16'd1];
        upd_nz = 1'b0;
        take = 1'b0;
        res = '0;
        case (op)
            OP_LDA: begin
                a = arg;
                res = a;
                upd_nz = 1'b1;
            end
            OP_LDX: begin
                x = arg;
                res = x;
                upd_nz = 1'b1;
            end
            OP_ADC: begin
                wide = int'(a) + int'(arg) + int'(c);
                a = DATA_W'(wide);
                c = (wide >= 256);
                res = a;
                upd_nz = 1'b1;
            end
            // carry clear means one more to borrow
            OP_SBC: begin
                wide = int'(a) - int'(arg) - (c ? 0 : 1);
                a = DATA_W'(wide);
                c = (wide >= 0);
                res = a;
                upd_nz = 1'b1;
            end
            OP_AND: begin
                a = a & arg;
                res = a;
                upd_nz = 1'b1;
            end
            OP_EOR: begin
                a = a ^ arg;
                res = a;
                upd_nz = 1'b1;
            end
            OP_STA: begin
                wr.addr = {8'h00, arg};
                wr.data = a;
                expected_q.push_back(wr);
            end
            OP_STX: begin
                wr.addr = {8'h00, arg};
                wr.data = x;
                expected_q.push_back(wr);
            end
            OP_INX: begin
                x = x + 8'd1;
                res = x;
                upd_nz = 1'b1;
            end
            OP_TAX: begin
                x = a;
                res = x;
                upd_nz = 1'b1;
            end
            OP_CLC: c = 1'b0;
            OP_SEC: c = 1'b1;
            OP_BEQ: take = z;
            OP_BNE: take = !z;
            OP_BCC: take = !c;
            OP_BCS: take = c;
            default: take = 1'b0;
        endcase
        if (upd_nz) begin
            z = (res == '0);
        end
        pc = pc + (has_operand(op) ? 16'd2 : 16'd1);
        // offset counts from the byte after the operand
        if (take) begin
            pc = pc + {{(ADDR_W-DATA_W){arg[DATA_W-1]}}, arg};
        end
    end
endtask

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_write(input logic [ADDR_W-1:0] exp_addr,
                           input logic [DATA_W-1:0] exp_data,
                           input logic [ADDR_W-1:0] got_addr,
                           input logic [DATA_W-1:0] got_data);
    if (got_addr !== exp_addr || got_data !== exp_data) begin
        abort_run($sformatf("CHECK FAILED at %0t: write expected [%h] <= %h, got [%h] <= %h",
                            $time, exp_addr, exp_data, got_addr, got_data));
    end
endtask

task automatic check_read_addr(input logic [ADDR_W-1:0] exp_addr,
                               input logic [ADDR_W-1:0] got_addr,
                               input logic got_r_en);
    if (got_addr !== exp_addr || got_r_en !== 1'b1) begin
        abort_run($sformatf("CHECK FAILED at %0t: first read expected %h, got %h with r_en %b",
                            $time, exp_addr, got_addr, got_r_en));
    end
endtask

`endif

//--- testbench/tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core
    import cpu_pkg::*;
();

    localparam int unsigned SEED = 32'ha723;
    localparam int PROG_LEN = 200;
    localparam int STALL_PCT = 20;
    localparam int WRITE_TIMEOUT = 4000;
    localparam int QUIET_CYCLES = 300;
    localparam int MAX_SKIP = 6;

    logic clock = 1'b0;
    logic reset_n;
    logic clock_en;
    logic [DATA_W-1:0] r_data;
    logic [ADDR_W-1:0] addr;
    logic mem_r_en;
    logic [DATA_W-1:0] w_data;

    logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
    logic [ADDR_W-1:0] prog_end;

`include "tb_cpu_model.svh"

    mem_write_t observed_q[$];
    mem_write_t seen_write;

    logic [DATA_W-1:0] op_table [17] = '{
        OP_LDA, OP_LDX, OP_ADC, OP_SBC, OP_AND, OP_EOR, OP_STA, OP_STX, OP_INX,
        OP_TAX, OP_CLC, OP_SEC, OP_NOP, OP_BEQ, OP_BNE, OP_BCC, OP_BCS
    };

    cpu_core cpu_core_inst (
        .i_clock    (clock),
        .i_reset_n  (reset_n),
        .i_clock_en (clock_en),
        .i_r_data   (r_data),
        .o_addr     (addr),
        .o_mem_r_en (mem_r_en),
        .o_w_data   (w_data)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic has_operand(input logic [DATA_W-1:0] op);
        case (op)
            OP_LDA, OP_LDX, OP_ADC, OP_SBC, OP_AND, OP_EOR,
            OP_STA, OP_STX, OP_BEQ, OP_BNE, OP_BCC, OP_BCS: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_branch(input logic [DATA_W-1:0] op);
        case (op)
            OP_BEQ, OP_BNE, OP_BCC, OP_BCS: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic build_program();
        logic [DATA_W-1:0] ops [PROG_LEN];
        logic [DATA_W-1:0] args [PROG_LEN];
        int size [PROG_LEN];
        int span;
        int skip;
        logic [ADDR_W-1:0] pos;
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            ops[i] = op_table[$urandom_range(16)];
            args[i] = DATA_W'($urandom_range(255));
            size[i] = has_operand(ops[i]) ? 2 : 1;
        end
        // forward offsets that always land on an opcode
        for (int i = 0; i < PROG_LEN; i++) begin
            if (is_branch(ops[i])) begin
                span = 0;
                skip = $urandom_range(4);
                for (int k = i + 1; k < PROG_LEN && k <= i + skip; k++) begin
                    if (span + size[k] > MAX_SKIP) begin
                        break;
                    end
                    span += size[k];
                end
                args[i] = DATA_W'(span);
            end
        end
        pos = RESET_PC;
        for (int i = 0; i < PROG_LEN; i++) begin
            mem[pos] = ops[i];
            if (size[i] == 2) begin
                mem[pos + 16'd1] = args[i];
            end
            pos = pos + ADDR_W'(size[i]);
        end
        prog_end = pos;
        // running off the end of the program only finds NOPs
        for (int i = prog_end; i < (1 << ADDR_W); i++) begin
            mem[i] = OP_NOP;
        end
    endtask

    task automatic wait_for_write(output mem_write_t wr);
        int cycles;
        cycles = 0;
        while (observed_q.size() == 0 && cycles < WRITE_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (observed_q.size() == 0) begin
            abort_run($sformatf("no write appeared within %0d cycles", WRITE_TIMEOUT));
        end else begin
            wr = observed_q.pop_front();
        end
    endtask

    ////////////////////////////////////////
    // clock, memory and stalls
    ////////////////////////////////////////

    initial begin
        forever #2 clock = ~clock;
    end

    // a write commits at the next rising edge only when enabled
    always @(negedge clock) begin
        clock_en = ($urandom_range(99) >= STALL_PCT);
        r_data = mem[addr];
        if (clock_en && !mem_r_en) begin
            seen_write.addr = addr;
            seen_write.data = w_data;
            observed_q.push_back(seen_write);
            mem[addr] = w_data;
        end
    end

    initial begin
        mem_write_t exp;
        mem_write_t got;
        reset_n = 1'b0;
        clock_en = 1'b0;
        r_data = '0;
        void'($urandom(SEED));
        build_program();
        run_model();
        if (expected_q.size() == 0) begin
            abort_run("the random program holds no store to check");
        end
        repeat (10) @(negedge clock);
        reset_n = 1'b1;
        check_read_addr(RESET_PC, addr, mem_r_en);
        while (expected_q.size() > 0) begin
            exp = expected_q.pop_front();
            wait_for_write(got);
            check_write(exp.addr, exp.data, got.addr, got.data);
        end
        // the tail of the program and the NOP area must stay silent
        repeat (QUIET_CYCLES) @(posedge clock);
        if (observed_q.size() != 0) begin
            abort_run("a write appeared after the last expected store");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+testbench
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_mem_if.sv
hw/cpu_regs.sv
hw/cpu_sequencer.sv
hw/cpu_core.sv
testbench/tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - hw/cpu_pkg.sv
  - hw/cpu_alu.sv
  - hw/cpu_mem_if.sv
  - hw/cpu_regs.sv
  - hw/cpu_sequencer.sv
  - hw/cpu_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_cpu_core.sv
